// ==== design/bus_consts.svh ====
// bus widths, memory depth, response FIFO depth and slave read latency
`ifndef BUS_CONSTS_SVH
`define BUS_CONSTS_SVH

// address and data path
`define BUS_ADDR_W 32
`define BUS_DATA_W 32

// word memory of the slave, upper address bits ignored so addresses wrap
`define MEM_WORDS 256

// entries in each response FIFO
`define RESP_FIFO_DEPTH 4

// cycles from ar acceptance to first r beat, must be at least 2
`define MEM_RD_LATENCY 2

`endif

// ==== design/bus_pkg.sv ====
// packed struct types for core requests, AXI channels and response beats
`include "bus_consts.svh"

package bus_pkg;

	// fetch side request, held stable while inst_sel_i is high
	typedef struct packed {
		logic [`BUS_ADDR_W-1:0] addr;
		logic [7:0] len; // beats minus one
		logic [2:0] size;
	} inst_req_t;

	// load/store request
	typedef struct packed {
		logic [`BUS_ADDR_W-1:0] addr;
		logic write;
		logic [2:0] size;
		logic [`BUS_DATA_W-1:0] wdata;
		logic [`BUS_DATA_W/8-1:0] strb;
	} data_req_t;

	typedef struct packed {
		logic [`BUS_ADDR_W-1:0] addr;
		logic [7:0] len;
		logic [2:0] size;
	} axi_ar_t;

	// writes are always single beat, so no len field
	typedef struct packed {
		logic [`BUS_ADDR_W-1:0] addr;
		logic [2:0] size;
	} axi_aw_t;

	typedef struct packed {
		logic [`BUS_DATA_W-1:0] data;
		logic [`BUS_DATA_W/8-1:0] strb;
		logic last;
	} axi_w_t;

	typedef struct packed {
		logic [`BUS_DATA_W-1:0] data;
		logic last;
	} axi_r_t;

	typedef struct packed {
		logic [`BUS_DATA_W-1:0] data;
		logic last; // final beat of the fetch burst
	} inst_beat_t;

	typedef struct packed {
		logic [`BUS_DATA_W-1:0] data;
		logic wr_done; // set for a write completion, data is zero then
	} data_resp_t;

endpackage

// ==== design/axi_arbiter.sv ====
// arbiter FSM granting the AXI master to the data or fetch port
module axi_arbiter (
	input logic clock,
	input logic reset,

	// core side
	input logic inst_sel_i,
	input bus_pkg::inst_req_t inst_req_i,
	input logic data_sel_i,
	input bus_pkg::data_req_t data_req_i,

	// AXI master channels
	output bus_pkg::axi_ar_t ar_o,
	output logic ar_valid_o,
	input logic ar_ready_i,
	output bus_pkg::axi_aw_t aw_o,
	output logic aw_valid_o,
	input logic aw_ready_i,
	output bus_pkg::axi_w_t w_o,
	output logic w_valid_o,
	input logic w_ready_i,
	input bus_pkg::axi_r_t r_i,
	input logic r_valid_i,
	output logic r_ready_o,
	input logic b_valid_i,
	output logic b_ready_o,

	// response FIFOs
	output logic inst_push_o,
	output bus_pkg::inst_beat_t inst_beat_o,
	output logic data_push_o,
	output bus_pkg::data_resp_t data_resp_o,
	input logic inst_full_i,
	input logic data_full_i
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DATA,
		ST_INST
	} arb_state_e;

	arb_state_e state_q, state_d;
	logic addr_done_q; // ar or aw already taken by the slave
	logic wdat_done_q; // w already taken
	logic busy_data, busy_inst;
	logic data_wr, data_rd;
	logic ar_fire, aw_fire, w_fire, r_fire, b_fire;

	assign busy_data = (state_q == ST_DATA);
	assign busy_inst = (state_q == ST_INST);
	assign data_wr = busy_data & data_req_i.write;
	assign data_rd = busy_data & ~data_req_i.write;

	assign ar_fire = ar_valid_o & ar_ready_i;
	assign aw_fire = aw_valid_o & aw_ready_i;
	assign w_fire = w_valid_o & w_ready_i;
	assign r_fire = r_valid_i & r_ready_o;
	assign b_fire = b_valid_i & b_ready_o;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (data_sel_i) begin // data wins a tie
					state_d = ST_DATA;
				end else if (inst_sel_i) begin
					state_d = ST_INST;
				end
			end
			ST_DATA: begin
				if (b_fire | (r_fire & r_i.last)) begin
					state_d = ST_IDLE;
				end
			end
			ST_INST: begin
				if (r_fire & r_i.last) begin
					state_d = ST_IDLE;
				end
			end
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= ST_IDLE;
			addr_done_q <= 1'b0;
			wdat_done_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_q == ST_IDLE) begin
				addr_done_q <= 1'b0;
				wdat_done_q <= 1'b0;
			end else begin
				if (ar_fire | aw_fire) begin
					addr_done_q <= 1'b1;
				end
				if (w_fire) begin
					wdat_done_q <= 1'b1;
				end
			end
		end
	end

	// address phase, valids drop once their handshake is done
	assign ar_valid_o = (data_rd | busy_inst) & ~addr_done_q;
	assign aw_valid_o = data_wr & ~addr_done_q;
	assign w_valid_o = data_wr & ~wdat_done_q;

	always_comb begin
		if (busy_data) begin
			ar_o.addr = data_req_i.addr;
			ar_o.len = 8'd0; // single beat load
			ar_o.size = data_req_i.size;
		end else begin
			ar_o.addr = inst_req_i.addr;
			ar_o.len = inst_req_i.len;
			ar_o.size = inst_req_i.size;
		end
	end

	assign aw_o.addr = data_req_i.addr;
	assign aw_o.size = data_req_i.size;
	assign w_o.data = data_req_i.wdata;
	assign w_o.strb = data_req_i.strb;
	assign w_o.last = 1'b1;

	// stall r while the owner's FIFO has no room
	assign r_ready_o = (data_rd & ~data_full_i) | (busy_inst & ~inst_full_i);
	assign b_ready_o = data_wr;

	// steer beats to the owner's FIFO
	assign inst_push_o = busy_inst & r_fire;
	assign inst_beat_o.data = r_i.data;
	assign inst_beat_o.last = r_i.last;

	assign data_push_o = busy_data & (r_fire | b_fire);
	assign data_resp_o.data = data_req_i.write ? '0 : r_i.data;
	assign data_resp_o.wr_done = data_req_i.write;

endmodule

// ==== design/resp_fifo.sv ====
// synchronous FIFO with a type parameter for the buffered payload
`include "bus_consts.svh"

module resp_fifo #(
	parameter type payload_t = logic
) (
	input logic clock,
	input logic reset,
	input logic push_i,
	input payload_t push_data_i,
	output logic full_o,
	input logic pop_i,
	output logic valid_o,
	output payload_t head_o
);

	localparam int DEPTH = `RESP_FIFO_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	payload_t buf_q [DEPTH];
	logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
	logic [PTR_W:0] count_q;
	logic do_push, do_pop;

	assign full_o = (count_q == (PTR_W+1)'(DEPTH));
	assign valid_o = (count_q != '0);
	assign head_o = buf_q[rd_ptr_q];

	assign do_push = push_i & ~full_o;
	assign do_pop = pop_i & valid_o;

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (do_push) begin
				wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			end
			if (do_pop) begin
				rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			end
			// simultaneous push and pop leaves the count alone
			if (do_push & ~do_pop) begin
				count_q <= count_q + 1'b1;
			end else if (do_pop & ~do_push) begin
				count_q <= count_q - 1'b1;
			end
		end
	end

	// storage
	always_ff @(posedge clock) begin
		if (do_push) begin
			buf_q[wr_ptr_q] <= push_data_i;
		end
	end

endmodule

// ==== design/axi_mem_slave.sv ====
// AXI word memory slave with read bursts and strobed single-beat writes
`include "bus_consts.svh"

module axi_mem_slave (
	input logic clock,
	input logic reset,
	input bus_pkg::axi_ar_t ar_i,
	input logic ar_valid_i,
	output logic ar_ready_o,
	input bus_pkg::axi_aw_t aw_i,
	input logic aw_valid_i,
	output logic aw_ready_o,
	input bus_pkg::axi_w_t w_i,
	input logic w_valid_i,
	output logic w_ready_o,
	output bus_pkg::axi_r_t r_o,
	output logic r_valid_o,
	input logic r_ready_i,
	output logic b_valid_o,
	input logic b_ready_i
);

	import bus_pkg::*;

	localparam int IDX_W = $clog2(`MEM_WORDS);
	localparam int LAT_W = $clog2(`MEM_RD_LATENCY + 1);
	localparam int NBYTES = `BUS_DATA_W / 8;

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_WAIT,
		RD_BURST
	} rd_state_e;

	logic [`BUS_DATA_W-1:0] mem [`MEM_WORDS];

	rd_state_e rd_state_q;
	logic r_valid_q;
	axi_r_t r_q;
	logic [IDX_W-1:0] rd_idx_q; // word of the beat on the bus
	logic [7:0] rd_cnt_q; // beats left after the current one
	logic [LAT_W-1:0] lat_q;
	logic ar_fire, rd_issue, rd_adv, rd_end;

	logic aw_got_q, w_got_q, b_valid_q;
	axi_aw_t aw_q;
	axi_w_t w_q;
	logic aw_fire, w_fire, wr_go;
	logic [IDX_W-1:0] wr_idx;
	logic [`BUS_DATA_W-1:0] wr_data;
	logic [NBYTES-1:0] wr_strb;

	// read side
	assign ar_ready_o = (rd_state_q == RD_IDLE);
	assign ar_fire = ar_valid_i & ar_ready_o;
	assign rd_issue = (rd_state_q == RD_WAIT) & (lat_q == LAT_W'(1));
	assign rd_adv = (rd_state_q == RD_BURST) & r_ready_i & ~r_q.last;
	assign rd_end = (rd_state_q == RD_BURST) & r_ready_i & r_q.last;

	always_ff @(posedge clock) begin
		if (reset) begin
			rd_state_q <= RD_IDLE;
			r_valid_q <= 1'b0;
		end else begin
			if (ar_fire) begin
				rd_state_q <= RD_WAIT;
			end else if (rd_issue) begin
				rd_state_q <= RD_BURST;
				r_valid_q <= 1'b1;
			end else if (rd_end) begin
				rd_state_q <= RD_IDLE;
				r_valid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (ar_fire) begin
			rd_idx_q <= ar_i.addr[IDX_W+1:2];
			rd_cnt_q <= ar_i.len;
			lat_q <= LAT_W'(`MEM_RD_LATENCY - 1);
		end else if (rd_state_q == RD_WAIT && !rd_issue) begin
			lat_q <= lat_q - 1'b1;
		end
		if (rd_issue) begin
			r_q.data <= mem[rd_idx_q];
			r_q.last <= (rd_cnt_q == 8'd0);
		end else if (rd_adv) begin
			rd_idx_q <= rd_idx_q + 1'b1; // wraps with the memory
			rd_cnt_q <= rd_cnt_q - 1'b1;
			r_q.data <= mem[rd_idx_q + 1'b1];
			r_q.last <= (rd_cnt_q == 8'd1);
		end
	end

	assign r_o = r_q;
	assign r_valid_o = r_valid_q;

	// write side, aw and w may arrive in either order
	assign aw_ready_o = ~aw_got_q & ~b_valid_q;
	assign w_ready_o = ~w_got_q & ~b_valid_q;
	assign aw_fire = aw_valid_i & aw_ready_o;
	assign w_fire = w_valid_i & w_ready_o;
	assign wr_go = (aw_got_q | aw_fire) & (w_got_q | w_fire);

	assign wr_idx = aw_got_q ? aw_q.addr[IDX_W+1:2] : aw_i.addr[IDX_W+1:2];
	assign wr_data = w_got_q ? w_q.data : w_i.data;
	assign wr_strb = w_got_q ? w_q.strb : w_i.strb;

	always_ff @(posedge clock) begin
		if (reset) begin
			aw_got_q <= 1'b0;
			w_got_q <= 1'b0;
			b_valid_q <= 1'b0;
		end else if (wr_go) begin
			aw_got_q <= 1'b0;
			w_got_q <= 1'b0;
			b_valid_q <= 1'b1;
		end else begin
			aw_got_q <= aw_got_q | aw_fire;
			w_got_q <= w_got_q | w_fire;
			if (b_ready_i) begin
				b_valid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (aw_fire) begin
			aw_q <= aw_i;
		end
		if (w_fire) begin
			w_q <= w_i;
		end
		if (wr_go) begin
			for (int i = 0; i < NBYTES; i++) begin
				if (wr_strb[i]) begin
					mem[wr_idx][8*i +: 8] <= wr_data[8*i +: 8]; // byte merge
				end
			end
		end
	end

	assign b_valid_o = b_valid_q;

endmodule

// ==== design/bus_top.sv ====
// top level with arbiter, instruction and data response FIFOs and memory slave
module bus_top (
	input logic clock,
	input logic reset,
	input logic inst_sel_i,
	input bus_pkg::inst_req_t inst_req_i,
	input logic data_sel_i,
	input bus_pkg::data_req_t data_req_i,
	output logic inst_valid_o,
	output bus_pkg::inst_beat_t inst_beat_o,
	input logic inst_pop_i,
	output logic data_valid_o,
	output bus_pkg::data_resp_t data_resp_o,
	input logic data_pop_i
);

	import bus_pkg::*;

	axi_ar_t ar;
	axi_aw_t aw;
	axi_w_t w;
	axi_r_t r;
	logic ar_valid, ar_ready, aw_valid, aw_ready, w_valid, w_ready;
	logic r_valid, r_ready, b_valid, b_ready;
	logic inst_push, inst_full, data_push, data_full;
	inst_beat_t inst_beat;
	data_resp_t data_resp;

	axi_arbiter arb_i (
		.clock(clock), .reset(reset),
		.inst_sel_i(inst_sel_i), .inst_req_i(inst_req_i),
		.data_sel_i(data_sel_i), .data_req_i(data_req_i),
		.ar_o(ar), .ar_valid_o(ar_valid), .ar_ready_i(ar_ready),
		.aw_o(aw), .aw_valid_o(aw_valid), .aw_ready_i(aw_ready),
		.w_o(w), .w_valid_o(w_valid), .w_ready_i(w_ready),
		.r_i(r), .r_valid_i(r_valid), .r_ready_o(r_ready),
		.b_valid_i(b_valid), .b_ready_o(b_ready),
		.inst_push_o(inst_push), .inst_beat_o(inst_beat),
		.data_push_o(data_push), .data_resp_o(data_resp),
		.inst_full_i(inst_full), .data_full_i(data_full)
	);

	resp_fifo #(.payload_t(inst_beat_t)) inst_fifo_i (
		.clock(clock), .reset(reset),
		.push_i(inst_push), .push_data_i(inst_beat), .full_o(inst_full),
		.pop_i(inst_pop_i), .valid_o(inst_valid_o), .head_o(inst_beat_o)
	);

	resp_fifo #(.payload_t(data_resp_t)) data_fifo_i (
		.clock(clock), .reset(reset),
		.push_i(data_push), .push_data_i(data_resp), .full_o(data_full),
		.pop_i(data_pop_i), .valid_o(data_valid_o), .head_o(data_resp_o)
	);

	axi_mem_slave mem_i (
		.clock(clock), .reset(reset),
		.ar_i(ar), .ar_valid_i(ar_valid), .ar_ready_o(ar_ready),
		.aw_i(aw), .aw_valid_i(aw_valid), .aw_ready_o(aw_ready),
		.w_i(w), .w_valid_i(w_valid), .w_ready_o(w_ready),
		.r_o(r), .r_valid_o(r_valid), .r_ready_i(r_ready),
		.b_valid_o(b_valid), .b_ready_i(b_ready)
	);

endmodule

// ==== test/bus_chk.sv ====
// concurrent assertions on the arbiter AXI channels and response FIFO pushes
module bus_chk (
	input logic clock,
	input logic reset,
	input bus_pkg::axi_ar_t ar_i,
	input logic ar_valid_i,
	input logic ar_ready_i,
	input bus_pkg::axi_aw_t aw_i,
	input logic aw_valid_i,
	input logic aw_ready_i,
	input bus_pkg::axi_w_t w_i,
	input logic w_valid_i,
	input logic w_ready_i,
	input logic r_ready_i,
	input logic b_ready_i,
	input logic inst_push_i,
	input logic inst_full_i,
	input logic data_push_i,
	input logic data_full_i
);

	// pending transfers keep valid and payload until ready
	ar_hold: assert property (@(posedge clock) disable iff (reset)
		ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_i))
		else $error("ar valid dropped or its payload changed before ready");
	aw_hold: assert property (@(posedge clock) disable iff (reset)
		aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_i))
		else $error("aw valid dropped or its payload changed before ready");
	w_hold: assert property (@(posedge clock) disable iff (reset)
		w_valid_i && !w_ready_i |=> w_valid_i && $stable(w_i))
		else $error("w valid dropped or its payload changed before ready");

	aw_w_rise: assert property (@(posedge clock) disable iff (reset)
		$rose(aw_valid_i) == $rose(w_valid_i))
		else $error("aw valid and w valid did not rise together");

	inst_no_overflow: assert property (@(posedge clock) disable iff (reset)
		!(inst_push_i && inst_full_i))
		else $error("instruction beat pushed into a full FIFO");
	data_no_overflow: assert property (@(posedge clock) disable iff (reset)
		!(data_push_i && data_full_i))
		else $error("data response pushed into a full FIFO");

	quiet_after_reset: assert property (@(posedge clock)
		reset |=> !(ar_valid_i || aw_valid_i || w_valid_i || r_ready_i || b_ready_i
			|| inst_push_i || data_push_i))
		else $error("arbiter outputs active right after reset");

endmodule

bind axi_arbiter bus_chk chk_i (
	.clock(clock), .reset(reset),
	.ar_i(ar_o), .ar_valid_i(ar_valid_o), .ar_ready_i(ar_ready_i),
	.aw_i(aw_o), .aw_valid_i(aw_valid_o), .aw_ready_i(aw_ready_i),
	.w_i(w_o), .w_valid_i(w_valid_o), .w_ready_i(w_ready_i),
	.r_ready_i(r_ready_o), .b_ready_i(b_ready_o),
	.inst_push_i(inst_push_o), .inst_full_i(inst_full_i),
	.data_push_i(data_push_o), .data_full_i(data_full_i)
);

// ==== test/bus_tb.sv ====
// testbench for bus_top with scoreboard memory, directed tests and a value check task
`include "bus_consts.svh"

module bus_tb;

	import bus_pkg::*;

	localparam int TIMEOUT = 200; // cycles allowed for any single wait
	localparam int SW = `BUS_DATA_W / 8;

	typedef logic [`BUS_ADDR_W-1:0] addr_t;
	typedef logic [`BUS_DATA_W-1:0] word_t;

	logic clock;
	logic reset;
	logic inst_sel, data_sel, inst_pop, data_pop;
	inst_req_t inst_req;
	data_req_t data_req;
	logic inst_valid, data_valid;
	inst_beat_t inst_beat;
	data_resp_t data_resp;

	word_t sb_mem [`MEM_WORDS]; // expected memory contents
	int checks, errors, test_err0;
	int cycle;
	int resp_cyc; // cycle of the latest data response
	int beat_cyc; // cycle of the first beat of the latest fetch

	bus_top dut_i (
		.clock(clock), .reset(reset),
		.inst_sel_i(inst_sel), .inst_req_i(inst_req),
		.data_sel_i(data_sel), .data_req_i(data_req),
		.inst_valid_o(inst_valid), .inst_beat_o(inst_beat), .inst_pop_i(inst_pop),
		.data_valid_o(data_valid), .data_resp_o(data_resp), .data_pop_i(data_pop)
	);

	always #4 clock = ~clock;

	always @(posedge clock) begin
		cycle <= cycle + 1;
	end

	task automatic check_equal(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	// bits above the word index are ignored by the memory
	function automatic int word_of(input addr_t addr);
		return int'((addr >> 2) % `MEM_WORDS);
	endfunction

	function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
			input logic [SW-1:0] strb);
		word_t res;
		res = old_w;
		for (int i = 0; i < SW; i++) begin
			if (strb[i]) begin
				res[8*i +: 8] = new_w[8*i +: 8];
			end
		end
		return res;
	endfunction

	function automatic addr_t rand_addr();
		return addr_t'($urandom() % `MEM_WORDS) << 2; // word aligned, inside the memory
	endfunction

	// one load or store, called and returning on a falling edge
	task automatic data_access(input logic write, input addr_t addr, input word_t wdata,
			input logic [SW-1:0] strb, output word_t rd);
		int n;
		data_resp_t resp;
		data_req = '{addr: addr, write: write, size: 3'd2, wdata: wdata, strb: strb};
		data_sel = 1'b1;
		n = 0;
		do begin
			@(negedge clock);
			n++;
		end while (!data_valid && n < TIMEOUT);
		data_sel = 1'b0;
		rd = '0;
		if (!data_valid) begin
			errors++;
			$display("timeout: no data response for address 0x%0h", addr);
			return;
		end
		resp_cyc = cycle;
		resp = data_resp;
		data_pop = 1'b1;
		@(negedge clock);
		data_pop = 1'b0;
		check_equal("data_resp_o.wr_done", 64'(resp.wr_done), 64'(write));
		if (write) begin
			sb_mem[word_of(addr)] = merge_bytes(sb_mem[word_of(addr)], wdata, strb);
		end else begin
			rd = resp.data;
			check_equal("data_resp_o.data", 64'(resp.data), 64'(sb_mem[word_of(addr)]));
		end
	endtask

	task automatic release_select();
		int n;
		logic seen;
		seen = 1'b0;
		n = 0;
		while (!seen && n < TIMEOUT) begin
			seen = dut_i.arb_i.inst_push_o & dut_i.arb_i.inst_beat_o.last; // pushed at next edge
			@(negedge clock);
			n++;
		end
		inst_sel = 1'b0;
		if (!seen) begin
			errors++;
			$display("timeout: the last fetch beat was never produced");
		end
	endtask

	task automatic consume_beats(input addr_t addr, input int beats, input int hold,
			input int gap);
		int n;
		repeat (hold) @(negedge clock);
		for (int i = 0; i < beats; i++) begin
			n = 0;
			while (!inst_valid && n < TIMEOUT) begin
				@(negedge clock);
				n++;
			end
			if (!inst_valid) begin
				errors++;
				$display("timeout: fetch beat %0d of %0d never arrived", i + 1, beats);
				return;
			end
			if (beat_cyc < 0) begin
				beat_cyc = cycle;
			end
			check_equal("inst_beat_o.data", 64'(inst_beat.data),
				64'(sb_mem[word_of(addr + addr_t'(4 * i))]));
			check_equal("inst_beat_o.last", 64'(inst_beat.last), 64'(i == beats - 1));
			inst_pop = 1'b1;
			@(negedge clock);
			inst_pop = 1'b0;
			repeat (gap) @(negedge clock);
		end
		repeat (4) @(negedge clock);
		check_equal("inst_valid_o", 64'(inst_valid), 64'(0)); // no extra beats
	endtask

	// hold pops off for hold cycles, then pop one beat every gap+1 cycles
	task automatic fetch_burst(input addr_t addr, input int beats, input int hold,
			input int gap);
		inst_req = '{addr: addr, len: 8'(beats - 1), size: 3'd2};
		inst_sel = 1'b1;
		beat_cyc = -1;
		fork
			release_select();
			consume_beats(addr, beats, hold, gap);
		join
	endtask

	task automatic fill_words(input addr_t base, input int n);
		word_t rd;
		for (int i = 0; i < n; i++) begin
			data_access(1'b1, base + addr_t'(4 * i), $urandom(), '1, rd);
		end
	endtask

	task automatic write_then_read();
		addr_t addrs [4];
		word_t rd;
		foreach (addrs[i]) begin
			addrs[i] = rand_addr();
			data_access(1'b1, addrs[i], $urandom(), '1, rd);
		end
		foreach (addrs[i]) begin
			data_access(1'b0, addrs[i], '0, '0, rd);
		end
	endtask

	task automatic partial_strobe();
		addr_t addr;
		word_t rd;
		addr = rand_addr();
		data_access(1'b1, addr, $urandom(), '1, rd);
		data_access(1'b1, addr, $urandom(), 4'b0101, rd);
		data_access(1'b0, addr, '0, '0, rd);
		data_access(1'b1, addr, $urandom(), 4'b1000, rd);
		data_access(1'b0, addr, '0, '0, rd);
	endtask

	task automatic fetch_in_order();
		addr_t base;
		base = rand_addr();
		fill_words(base, 4);
		fetch_burst(base, 4, 0, 0);
	endtask

	task automatic fetch_backpressure();
		addr_t base;
		base = rand_addr();
		fill_words(base, 8);
		fetch_burst(base, 8, 20, 3); // FIFO is long full after 20 cycles
	endtask

	task automatic data_over_fetch();
		addr_t base, daddr;
		word_t rd;
		base = rand_addr();
		daddr = rand_addr();
		data_access(1'b1, daddr, $urandom(), '1, rd);
		fill_words(base, 4);
		fork
			data_access(1'b0, daddr, '0, '0, rd);
			fetch_burst(base, 4, 0, 0);
		join
		if (beat_cyc < 0 || resp_cyc >= beat_cyc) begin
			errors++;
			$display("data response did not complete before the first fetch beat");
		end
	endtask

	task automatic address_wrap();
		addr_t hi;
		word_t wdata, rd;
		hi = addr_t'($urandom() & 32'hffff_fffc) | addr_t'(4 * `MEM_WORDS);
		wdata = $urandom();
		data_access(1'b1, hi, wdata, '1, rd);
		data_access(1'b0, hi % addr_t'(4 * `MEM_WORDS), '0, '0, rd);
		check_equal("alias read data", 64'(rd), 64'(wdata));
	endtask

	task automatic finish_test(input string name);
		$display("%s: %0d errors", name, errors - test_err0);
		test_err0 = errors;
	endtask

	initial begin
		void'($urandom(32'hf3220376));
		clock = 1'b0;
		reset = 1'b1;
		inst_sel = 1'b0;
		data_sel = 1'b0;
		inst_pop = 1'b0;
		data_pop = 1'b0;
		inst_req = '0;
		data_req = '0;
		checks = 0;
		errors = 0;
		test_err0 = 0;
		cycle = 0;
		resp_cyc = 0;
		beat_cyc = -1;
		repeat (10) @(negedge clock);
		reset = 1'b0;
		check_equal("inst_valid_o", 64'(inst_valid), 64'(0));
		check_equal("data_valid_o", 64'(data_valid), 64'(0));
		finish_test("reset");
		write_then_read();
		finish_test("write then read");
		partial_strobe();
		finish_test("partial strobes");
		fetch_in_order();
		finish_test("fetch burst");
		fetch_backpressure();
		finish_test("back-pressure");
		data_over_fetch();
		finish_test("arbitration");
		address_wrap();
		finish_test("address wrap");
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+design
design/bus_pkg.sv
design/axi_arbiter.sv
design/resp_fifo.sv
design/axi_mem_slave.sv
design/bus_top.sv
test/bus_chk.sv
test/bus_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the bus testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module bus_tb -f compile.f -o bus_sim
if ./obj_dir/bus_sim | tee /dev/stderr | grep -Fx "RESULT: PASS" > /dev/null; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
